//--- rtos_consts.svh
/* scheduler sizing constants, include wherever task count, widths or timing are needed
   lower priority value is more urgent */

`ifndef RTOS_CONSTS_SVH
`define RTOS_CONSTS_SVH

// ------------------------------
// task table
// ------------------------------
`define RTOS_TASK_NUM       16
`define RTOS_ID_WIDTH       4
`define RTOS_PRI_WIDTH      4

// ------------------------------
// queue and dispatch
// ------------------------------
`define RTOS_QUE_SIZE       16      // default ready queue depth
`define RTOS_SWITCH_CYCLES  4       // context switch delay in clocks

`endif

//--- rtos_pkg.sv
/* shared scheduler types, referenced by scoped names from the controller,
   queue, dispatcher and testbench */

`default_nettype none

`include "rtos_consts.svh"

package rtos_pkg;

    typedef logic [`RTOS_ID_WIDTH-1:0]              task_id_t;
    typedef logic [`RTOS_PRI_WIDTH-1:0]             task_pri_t;
    typedef logic [$clog2(`RTOS_TASK_NUM+1)-1:0]    que_count_t;   // 0 .. task count

    // software command opcodes
    typedef enum logic {
        wakeup = 1'b0,
        sleep  = 1'b1
    } cmd_op_t;

    typedef enum logic [1:0] {
        idle,
        switching,
        running
    } disp_state_t;

endpackage

`default_nettype wire

//--- rtos_task_ctl.sv
/* task controller, keeps the ready table and turns wakeup/sleep commands
   into add/remove strobes for the ready queue */

`timescale 1ns/1ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_task_ctl (
    input  wire                     clk,
    input  wire                     reset,

    input  wire                     cmd_valid,
    input  wire rtos_pkg::cmd_op_t  cmd_op,
    input  wire rtos_pkg::task_id_t cmd_id,
    input  wire rtos_pkg::task_pri_t cmd_pri,

    output logic                    add_valid,
    output rtos_pkg::task_id_t      add_id,
    output rtos_pkg::task_pri_t     add_pri,
    output logic                    remove_valid,
    output rtos_pkg::task_id_t      remove_id
);

    logic [`RTOS_TASK_NUM-1:0] ready;     // one bit per task
    logic                      do_add;
    logic                      do_remove;

    // redundant commands are dropped here
    assign do_add    = cmd_valid && (cmd_op == rtos_pkg::wakeup) && !ready[cmd_id];
    assign do_remove = cmd_valid && (cmd_op == rtos_pkg::sleep) && ready[cmd_id];

    // ------------------------------
    // ready table and strobes
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ready        <= '0;
            add_valid    <= 1'b0;
            remove_valid <= 1'b0;
        end else begin
            add_valid    <= do_add;
            remove_valid <= do_remove;
            if (do_add) begin
                ready[cmd_id] <= 1'b1;
            end
            if (do_remove) begin
                ready[cmd_id] <= 1'b0;
            end
        end
    end

    // command payload, qualified by the strobes
    always_ff @(posedge clk) begin
        add_id    <= cmd_id;
        add_pri   <= cmd_pri;
        remove_id <= cmd_id;
    end

    // queue sees one operation per cycle at most
    a_one_op: assert property (@(posedge clk) disable iff (reset)
        !(add_valid && remove_valid));

endmodule

`default_nettype wire

//--- rtos_ready_queue.sv
/* sorted ready queue, most urgent task in slot 0 and arrival order among equals
   head updates directly, later slots move one cycle after the strobe */

`timescale 1ns/1ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_ready_queue #(
    parameter int que_size = `RTOS_QUE_SIZE
) (
    input  wire                         clk,
    input  wire                         reset,

    input  wire                         add_valid,
    input  wire rtos_pkg::task_id_t     add_id,
    input  wire rtos_pkg::task_pri_t    add_pri,
    input  wire                         remove_valid,
    input  wire rtos_pkg::task_id_t     remove_id,

    output rtos_pkg::task_id_t          top_id,
    output rtos_pkg::task_pri_t         top_pri,
    output logic                        top_valid,
    output rtos_pkg::que_count_t        count
);

    typedef enum logic [1:0] {
        stay,
        forward,
        backward,
        insert
    } move_t;

    // slot que_size is a constant empty tail
    rtos_pkg::task_id_t   slot_id   [que_size+1];
    rtos_pkg::task_pri_t  slot_pri  [que_size+1];
    logic [que_size:0]    slot_valid;
    move_t                slot_move [1:que_size-1];   // head has no move flag

    rtos_pkg::task_id_t   carry_id;       // object handed to an insert slot
    rtos_pkg::task_pri_t  carry_pri;
    logic                 carry_valid;

    rtos_pkg::task_id_t   nxt_id    [que_size+1];
    rtos_pkg::task_pri_t  nxt_pri   [que_size+1];
    logic [que_size:0]    nxt_valid;

    logic [que_size-1:0]  add_hit;        // slot takes the new item or shifts back
    logic [que_size-1:0]  rm_from;        // slot at or after the removed id
    logic                 head_ins;
    logic                 head_rm;

    // ------------------------------
    // apply pending moves
    // ------------------------------
    always_comb begin
        nxt_id[0]    = slot_id[0];        // head is written directly
        nxt_pri[0]   = slot_pri[0];
        nxt_valid[0] = slot_valid[0];
        for (int i = 1; i < que_size; i++) begin
            nxt_id[i]    = slot_id[i];
            nxt_pri[i]   = slot_pri[i];
            nxt_valid[i] = slot_valid[i];
            case (slot_move[i])
                forward: begin
                    nxt_id[i]    = slot_id[i+1];
                    nxt_pri[i]   = slot_pri[i+1];
                    nxt_valid[i] = slot_valid[i+1];
                end
                backward: begin
                    nxt_id[i]    = slot_id[i-1];
                    nxt_pri[i]   = slot_pri[i-1];
                    nxt_valid[i] = slot_valid[i-1];
                end
                insert: begin
                    nxt_id[i]    = carry_id;
                    nxt_pri[i]   = carry_pri;
                    nxt_valid[i] = carry_valid;
                end
                default: ;
            endcase
        end
        nxt_id[que_size]    = '0;
        nxt_pri[que_size]   = '0;
        nxt_valid[que_size] = 1'b0;
    end

    // search on the settled view
    always_comb begin
        logic found;
        found = 1'b0;
        for (int i = 0; i < que_size; i++) begin
            add_hit[i] = !nxt_valid[i] || (add_pri < nxt_pri[i]);   // strictly greater
            found      = found || (nxt_valid[i] && (nxt_id[i] == remove_id));
            rm_from[i] = found;
        end
    end

    assign head_ins = add_valid && add_hit[0];
    assign head_rm  = remove_valid && !add_valid && rm_from[0];

    // ------------------------------
    // control state
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            count       <= '0;
            slot_valid  <= '0;
            carry_valid <= 1'b0;
            for (int i = 1; i < que_size; i++) begin
                slot_move[i] <= stay;
            end
        end else begin
            slot_valid  <= nxt_valid;
            carry_valid <= head_ins ? nxt_valid[0] : 1'b1;
            for (int i = 1; i < que_size; i++) begin
                slot_move[i] <= stay;
            end
            if (add_valid) begin
                count <= count + 1'b1;
                for (int i = 1; i < que_size; i++) begin
                    if (add_hit[i]) begin
                        slot_move[i] <= (i > 1 && add_hit[i-1]) ? backward : insert;
                    end
                end
                if (head_ins) begin
                    slot_valid[0] <= 1'b1;
                end
            end else if (remove_valid) begin
                for (int i = 1; i < que_size; i++) begin
                    if (rm_from[i]) begin
                        slot_move[i] <= forward;
                    end
                end
                if (head_rm) begin
                    slot_valid[0] <= nxt_valid[1];
                end
                if (rm_from[que_size-1]) begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        for (int i = 0; i <= que_size; i++) begin
            slot_id[i]  <= nxt_id[i];
            slot_pri[i] <= nxt_pri[i];
        end
        carry_id  <= add_id;
        carry_pri <= add_pri;
        if (head_ins) begin
            slot_id[0]  <= add_id;
            slot_pri[0] <= add_pri;
            carry_id    <= nxt_id[0];       // old head goes to slot 1
            carry_pri   <= nxt_pri[0];
        end else if (head_rm) begin
            slot_id[0]  <= nxt_id[1];
            slot_pri[0] <= nxt_pri[1];
        end
    end

    assign top_id    = slot_id[0];
    assign top_pri   = slot_pri[0];
    assign top_valid = slot_valid[0];

    a_count_max: assert property (@(posedge clk) disable iff (reset)
        count <= que_size);

endmodule

`default_nettype wire

//--- rtos_dispatcher.sv
/* dispatcher, follows the queue head through a fixed context switch delay
   and reports the task that now runs */

`timescale 1ns/1ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_dispatcher (
    input  wire                         clk,
    input  wire                         reset,

    input  wire rtos_pkg::task_id_t     top_id,
    input  wire rtos_pkg::task_pri_t    top_pri,
    input  wire                         top_valid,

    output rtos_pkg::task_id_t          run_id,
    output rtos_pkg::task_pri_t         run_pri,
    output logic                        run_valid,
    output logic                        dispatch
);

    localparam int               cnt_w    = $clog2(`RTOS_SWITCH_CYCLES + 1);
    localparam logic [cnt_w-1:0] cnt_load = cnt_w'(`RTOS_SWITCH_CYCLES - 1);

    rtos_pkg::disp_state_t  state;
    logic [cnt_w-1:0]       wait_cnt;
    rtos_pkg::task_id_t     sw_id;          // head being switched to

    // ------------------------------
    // switch FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= rtos_pkg::idle;
            wait_cnt  <= '0;
            sw_id     <= '0;
            run_id    <= '0;
            run_pri   <= '0;
            run_valid <= 1'b0;
            dispatch  <= 1'b0;
        end else begin
            dispatch <= 1'b0;
            case (state)
                rtos_pkg::idle: begin
                    if (top_valid) begin
                        state    <= rtos_pkg::switching;
                        sw_id    <= top_id;
                        wait_cnt <= cnt_load;
                    end
                end

                rtos_pkg::switching: begin
                    if (!top_valid) begin
                        state     <= rtos_pkg::idle;
                        run_valid <= 1'b0;
                    end else if (top_id != sw_id) begin
                        sw_id    <= top_id;         // head moved, start over
                        wait_cnt <= cnt_load;
                    end else if (wait_cnt == '0) begin
                        state     <= rtos_pkg::running;
                        run_id    <= top_id;
                        run_pri   <= top_pri;
                        run_valid <= 1'b1;
                        dispatch  <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end

                rtos_pkg::running: begin
                    if (!top_valid) begin
                        state     <= rtos_pkg::idle;
                        run_valid <= 1'b0;
                    end else if (top_id != run_id) begin
                        state    <= rtos_pkg::switching;   // old task runs until done
                        sw_id    <= top_id;
                        wait_cnt <= cnt_load;
                    end
                end

                default: begin
                    state     <= rtos_pkg::idle;
                    run_valid <= 1'b0;
                end
            endcase
        end
    end

    a_dispatch_run: assert property (@(posedge clk) disable iff (reset)
        dispatch |-> run_valid);

endmodule

`default_nettype wire

//--- rtos_sched_top.sv
/* scheduler core top level, command port in and running task out
   controller feeds the ready queue, dispatcher follows its head */

`timescale 1ns/1ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_sched_top (
    input  wire                         clk,
    input  wire                         reset,

    input  wire                         cmd_valid,
    input  wire rtos_pkg::cmd_op_t      cmd_op,
    input  wire rtos_pkg::task_id_t     cmd_id,
    input  wire rtos_pkg::task_pri_t    cmd_pri,

    output wire rtos_pkg::task_id_t     top_id,
    output wire                         top_valid,
    output wire rtos_pkg::que_count_t   ready_count,
    output wire rtos_pkg::task_id_t     run_id,
    output wire rtos_pkg::task_pri_t    run_pri,
    output wire                         run_valid,
    output wire                         dispatch
);

    // controller to queue
    wire                        add_valid;
    wire rtos_pkg::task_id_t    add_id;
    wire rtos_pkg::task_pri_t   add_pri;
    wire                        remove_valid;
    wire rtos_pkg::task_id_t    remove_id;

    wire rtos_pkg::task_pri_t   top_pri;    // only the dispatcher needs it

    rtos_task_ctl rtos_task_ctl_inst (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_id       (cmd_id),
        .cmd_pri      (cmd_pri),
        .add_valid    (add_valid),
        .add_id       (add_id),
        .add_pri      (add_pri),
        .remove_valid (remove_valid),
        .remove_id    (remove_id)
    );

    rtos_ready_queue #(
        .que_size     (`RTOS_QUE_SIZE)
    ) rtos_ready_queue_inst (
        .clk          (clk),
        .reset        (reset),
        .add_valid    (add_valid),
        .add_id       (add_id),
        .add_pri      (add_pri),
        .remove_valid (remove_valid),
        .remove_id    (remove_id),
        .top_id       (top_id),
        .top_pri      (top_pri),
        .top_valid    (top_valid),
        .count        (ready_count)
    );

    rtos_dispatcher rtos_dispatcher_inst (
        .clk          (clk),
        .reset        (reset),
        .top_id       (top_id),
        .top_pri      (top_pri),
        .top_valid    (top_valid),
        .run_id       (run_id),
        .run_pri      (run_pri),
        .run_valid    (run_valid),
        .dispatch     (dispatch)
    );

endmodule

`default_nettype wire

//--- rtos_sched_tb.sv
/* testbench for the scheduler core, replays rtos_sched_golden.txt, checks dispatch
   behavior and runs a random command sequence against a queue model */

`timescale 1ns/1ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_sched_tb;

    localparam int clk_period = 20;
    localparam int rand_cmds  = 200;

    logic                    clk;
    logic                    reset;
    logic                    cmd_valid;
    rtos_pkg::cmd_op_t       cmd_op;
    rtos_pkg::task_id_t      cmd_id;
    rtos_pkg::task_pri_t     cmd_pri;
    rtos_pkg::task_id_t      top_id;
    logic                    top_valid;
    rtos_pkg::que_count_t    ready_count;
    rtos_pkg::task_id_t      run_id;
    rtos_pkg::task_pri_t     run_pri;
    logic                    run_valid;
    logic                    dispatch;

    // golden lines
    rtos_pkg::cmd_op_t g_op[$];
    int g_id[$];
    int g_pri[$];
    int g_exp_id[$];
    int g_exp_valid[$];
    int g_exp_cnt[$];

    // reference queue, most urgent first
    int model_id[$];
    int model_pri[$];
    bit model_ready [`RTOS_TASK_NUM];

    // checks waiting for their cycle
    int due_q[$];
    int exp_id_q[$];
    int exp_valid_q[$];
    int exp_cnt_q[$];

    int          cyc;
    int          err_cnt;
    int          tests_run;
    int          tests_ok;
    int          dispatch_cnt;
    int          golden_n;
    bit          load_done;
    logic [31:0] rng;

    rtos_sched_top rtos_sched_top_inst (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_id      (cmd_id),
        .cmd_pri     (cmd_pri),
        .top_id      (top_id),
        .top_valid   (top_valid),
        .ready_count (ready_count),
        .run_id      (run_id),
        .run_pri     (run_pri),
        .run_valid   (run_valid),
        .dispatch    (dispatch)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(negedge clk) begin
        if (!reset && dispatch) begin
            dispatch_cnt++;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // ------------------------------
    // clocking of commands and checks
    // ------------------------------
    task automatic tick();
        int eid;
        int ev;
        int ec;
        @(posedge clk);
        #1;
        cyc++;
        while (due_q.size() > 0 && due_q[0] == cyc) begin
            eid = exp_id_q.pop_front();
            ev  = exp_valid_q.pop_front();
            ec  = exp_cnt_q.pop_front();
            void'(due_q.pop_front());
            check_value("head valid", int'(top_valid), ev);
            if (ev != 0) begin
                check_value("head id", int'(top_id), eid);
            end
            check_value("ready count", int'(ready_count), ec);
        end
    endtask

    task automatic issue(input rtos_pkg::cmd_op_t op, input int id, input int pri,
                         input int eid, input int ev, input int ec);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_id    = rtos_pkg::task_id_t'(id);
        cmd_pri   = rtos_pkg::task_pri_t'(pri);
        due_q.push_back(cyc + 2);      // controller stage plus queue stage
        exp_id_q.push_back(eid);
        exp_valid_q.push_back(ev);
        exp_cnt_q.push_back(ec);
        tick();
        cmd_valid = 1'b0;
    endtask

    task automatic settle(input int extra);
        cmd_valid = 1'b0;
        while (due_q.size() > 0) begin
            tick();
        end
        repeat (extra) tick();
    endtask

    task automatic model_apply(input rtos_pkg::cmd_op_t op, input int id, input int pri);
        int pos;
        pos = 0;
        if (op == rtos_pkg::wakeup && !model_ready[id]) begin
            while (pos < model_id.size() && model_pri[pos] <= pri) begin
                pos++;                 // behind all equals
            end
            model_id.insert(pos, id);
            model_pri.insert(pos, pri);
            model_ready[id] = 1'b1;
        end else if (op == rtos_pkg::sleep && model_ready[id]) begin
            while (model_id[pos] != id) begin
                pos++;
            end
            model_id.delete(pos);
            model_pri.delete(pos);
            model_ready[id] = 1'b0;
        end
    endtask

    task automatic send(input rtos_pkg::cmd_op_t op, input int id, input int pri);
        model_apply(op, id, pri);
        if (model_id.size() > 0) begin
            issue(op, id, pri, model_id[0], 1, model_id.size());
        end else begin
            issue(op, id, pri, 0, 0, 0);
        end
    endtask

    function automatic int pick_id(input int start, input bit want_ready);
        int id;
        for (int k = 0; k < `RTOS_TASK_NUM; k++) begin
            id = (start + k) % `RTOS_TASK_NUM;
            if (model_ready[id] == want_ready) begin
                return id;
            end
        end
        return start;
    endfunction

    task automatic wait_dispatch(input int base, input int limit);
        int n;
        n = 0;
        while (dispatch_cnt == base && n < limit) begin
            tick();
            n++;
        end
        if (dispatch_cnt == base) begin
            $display("no dispatch pulse within %0d cycles, at %0t ns", limit, $time);
            err_cnt++;
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic load_golden();
        int    fd;
        int    n;
        int    op;
        int    id;
        int    pri;
        int    eid;
        int    ev;
        int    ec;
        string line;
        fd = $fopen("rtos_sched_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open rtos_sched_golden.txt");
            err_cnt++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d", op, id, pri, eid, ev, ec);
                    if (n == 6) begin
                        g_op.push_back(rtos_pkg::cmd_op_t'(op));
                        g_id.push_back(id);
                        g_pri.push_back(pri);
                        g_exp_id.push_back(eid);
                        g_exp_valid.push_back(ev);
                        g_exp_cnt.push_back(ec);
                    end else begin
                        $display("golden file line could not be read: %s", line);
                        err_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
        golden_n  = g_op.size();
        load_done = 1'b1;
    endtask

    task automatic golden_test();
        for (int i = 0; i < golden_n; i++) begin
            model_apply(g_op[i], g_id[i], g_pri[i]);
            issue(g_op[i], g_id[i], g_pri[i], g_exp_id[i], g_exp_valid[i], g_exp_cnt[i]);
        end
        settle(0);
    endtask

    task automatic dispatch_test();
        int base;
        for (int i = 0; i < `RTOS_TASK_NUM; i++) begin
            if (model_ready[i]) begin
                send(rtos_pkg::sleep, i, 0);
            end
        end
        settle(2);
        check_value("run valid on empty queue", int'(run_valid), 0);

        base = dispatch_cnt;
        send(rtos_pkg::wakeup, 3, 7);
        wait_dispatch(base, 40);
        settle(20);                    // window for a stray second pulse
        check_value("dispatch pulses", dispatch_cnt - base, 1);
        check_value("run id", int'(run_id), 3);
        check_value("run pri", int'(run_pri), 7);
        check_value("run valid", int'(run_valid), 1);

        // head moves twice inside the switch delay
        base = dispatch_cnt;
        send(rtos_pkg::wakeup, 9, 4);
        send(rtos_pkg::wakeup, 12, 2);
        wait_dispatch(base, 40);
        settle(20);
        check_value("dispatch pulses after head change", dispatch_cnt - base, 1);
        check_value("run id after head change", int'(run_id), 12);
        check_value("run pri after head change", int'(run_pri), 2);

        base = dispatch_cnt;
        send(rtos_pkg::sleep, 12, 0);
        send(rtos_pkg::sleep, 9, 0);
        send(rtos_pkg::sleep, 3, 0);
        settle(2);
        check_value("dispatch pulses while emptying", dispatch_cnt - base, 0);
        check_value("run valid after emptying", int'(run_valid), 0);
    endtask

    task automatic random_test(input int n);
        logic [31:0]       r;
        rtos_pkg::cmd_op_t op;
        int                id;
        int                pri;
        int                peak;
        peak = 0;
        for (int c = 0; c < n; c++) begin
            rng = xorshift(rng);
            r   = rng;
            // first half 1 in 8 sleeps, second half 1 in 8 wakeups
            op = rtos_pkg::wakeup;
            if ((c < n / 2) == (r[2:0] == 3'd0)) begin
                op = rtos_pkg::sleep;
            end
            id  = int'(r[7:4]);
            pri = int'(r[11:8]) % 5;   // few levels, many ties
            if (r[14:12] != 3'd0) begin
                id = pick_id(id, op == rtos_pkg::sleep);
            end
            send(op, id, pri);
            if (model_id.size() > peak) begin
                peak = model_id.size();
            end
            if (r[17:15] == 3'd0) begin
                tick();                // idle gap now and then
            end
        end
        settle(0);
        check_value("peak ready count", peak, `RTOS_TASK_NUM);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - err_before);
        end
    endtask

    // ------------------------------
    // main flow and watchdog
    // ------------------------------
    initial begin
        int mark;
        clk       = 1'b0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = rtos_pkg::wakeup;
        cmd_id    = '0;
        cmd_pri   = '0;
        rng       = 32'd89;
        load_golden();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        mark = err_cnt;
        golden_test();
        end_test("golden", mark);
        mark = err_cnt;
        dispatch_test();
        end_test("dispatch", mark);
        mark = err_cnt;
        random_test(rand_cmds);
        end_test("random", mark);

        $display("%0d tests, %0d ok, %0d errors", tests_run, tests_ok, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (load_done);
        #((golden_n + rand_cmds + 100) * 10 * clk_period);
        $display("watchdog expired, the tests did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtos_sched_golden.txt
# op (0 wakeup, 1 sleep), id, pri, then expected head id, head valid, ready count
# commands go out on consecutive cycles, each checked two cycles after its strobe
# mixed priorities
0 2 9 2 1 1
0 5 3 5 1 2
0 7 12 5 1 3
0 1 6 5 1 4
0 0 1 0 1 5
# redundant commands
0 5 0 0 1 5
1 9 0 0 1 5
# equal priorities keep arrival order
0 10 1 0 1 6
1 0 0 10 1 5
0 11 1 10 1 6
1 10 0 11 1 5
# removal from middle, tail and head
1 1 0 11 1 4
1 7 0 11 1 3
1 11 0 5 1 2
1 5 0 2 1 1
0 4 9 2 1 2
1 2 0 4 1 1
0 6 15 4 1 2
0 8 0 8 1 3
1 8 0 4 1 2
1 4 0 6 1 1
1 6 0 0 0 0
1 6 0 0 0 0
0 15 5 15 1 1
0 14 5 15 1 2
0 13 4 13 1 3
1 15 0 13 1 2
1 13 0 14 1 1
0 3 0 3 1 2
1 14 0 3 1 1

//--- rtos_sched_top.f
+incdir+.
rtos_pkg.sv
rtos_task_ctl.sv
rtos_ready_queue.sv
rtos_dispatcher.sv
rtos_sched_top.sv
rtos_sched_tb.sv

//--- Makefile
# Verilator build and run of the scheduler testbench
TOP := rtos_sched_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f rtos_sched_top.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

# fails unless the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
